//--- files.f
+incdir+test
logic/fpu_pkg.sv
logic/fpu_decoder.sv
logic/fpu_regfile.sv
logic/fpu_fast_pipe.sv
logic/fpu_to_int.sv
logic/fpu_top.sv
test/clock_gen.sv
test/fpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fpu_tb -f files.f -o fpu_sim

output=$(./obj_dir/fpu_sim)
echo "$output"

if echo "$output" | grep -q "^=== PASS ===$"; then
  exit 0
fi
exit 1

//--- test/fpu_ref.svh
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

function automatic logic ref_is_nan(fp_word_t x);
  return (&x[30:23]) && (|x[22:0]);
endfunction

function automatic logic ref_is_snan(fp_word_t x);
  return ref_is_nan(x) && (x[22] == 1'b0);
endfunction

// Unsigned key that sorts like the float value, -0 below +0
function automatic logic [31:0] order_key(fp_word_t x);
  return x[31] ? ~x : {1'b1, x[30:0]};
endfunction

function automatic fp_word_t ref_fast(fast_op_t op, fp_word_t a, fp_word_t b,
                                      fp_word_t int_in, output fflags_t fl);
  logic a_first;
  fl = '0;
  a_first = order_key(a) < order_key(b);
  case (op)
    FAST_SGNJ:  return {b[31], a[30:0]};
    FAST_SGNJN: return {!b[31], a[30:0]};
    FAST_SGNJX: return {a[31] != b[31], a[30:0]};
    FAST_MIN, FAST_MAX: begin
      fl[FLAG_NV] = ref_is_snan(a) || ref_is_snan(b);
      if (ref_is_nan(a) && ref_is_nan(b)) return CANON_NAN;
      if (ref_is_nan(a)) return b;
      if (ref_is_nan(b)) return a;
      if (op == FAST_MIN) return a_first ? a : b;
      return a_first ? b : a;
    end
    default:    return int_in;
  endcase
endfunction

function automatic logic [9:0] ref_class(fp_word_t a);
  int idx;
  if (ref_is_nan(a)) idx = a[22] ? 9 : 8;
  else if (&a[30:23]) idx = a[31] ? 0 : 7;
  else if (a[30:0] == 31'd0) idx = a[31] ? 3 : 4;
  else if (a[30:23] == 8'd0) idx = a[31] ? 2 : 5;
  else idx = a[31] ? 1 : 6;
  return 10'd1 << idx;
endfunction

function automatic fp_word_t ref_to_int(int_op_t op, fp_word_t a, fp_word_t b,
                                        output fflags_t fl);
  logic unord;
  logic zeros;
  logic eq;
  logic lt;
  fl = '0;
  unord = ref_is_nan(a) || ref_is_nan(b);
  zeros = (a[30:0] | b[30:0]) == 31'd0;
  eq = !unord && ((a == b) || zeros);
  lt = !unord && !zeros && (order_key(a) < order_key(b));
  case (op)
    INT_FEQ: begin
      fl[FLAG_NV] = ref_is_snan(a) || ref_is_snan(b);
      return {31'd0, eq};
    end
    INT_FLT: begin
      fl[FLAG_NV] = unord;
      return {31'd0, lt};
    end
    INT_FLE: begin
      fl[FLAG_NV] = unord;
      return {31'd0, lt || eq};
    end
    INT_CLASS:  return {22'd0, ref_class(a)};
    INT_MV_X_W: return a;
    default:    return '0;
  endcase
endfunction

`endif

//--- test/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
  import fpu_pkg::*;
  `include "fpu_ref.svh"

  // Reset, loads, moves, fast ops, compares, kills, collision, decode and drain
  localparam int STIM_CYCLES = 16 + 1 + 16 + 3 + 2 * 16 + 4 * 40 + 40 + 4 * 12 + 4 +
                               2 * 6 + 2 * 8 + 60 + 6;
  localparam int MAXC = 1024;

  logic      clock;
  logic      reset;
  fp_word_t  inst;
  logic      valid;
  fp_word_t  fromint_data;
  rm_t       fcsr_rm;
  logic      killx;
  logic      killm;
  logic      dmem_resp_val;
  reg_addr_t dmem_resp_tag;
  fp_word_t  dmem_resp_data;
  logic      fcsr_flags_valid;
  fflags_t   fcsr_flags_bits;
  fp_word_t  toint_data;
  fp_word_t  store_data;
  logic      fcsr_rdy;
  logic      illegal_rm;
  logic      dec_wen;
  logic      dec_ren1;
  logic      dec_ren2;

  int       cycle = 0;
  int       errors = 0;
  int       checks = 0;
  bit       checking = 0;
  fp_word_t model [32];

  // Expected toint/store values with the cycle they must show up in
  int       ev_cycle [$];
  bit       ev_store [$];
  fp_word_t ev_value [$];
  bit       exp_fv [MAXC];
  fflags_t  exp_bits [MAXC];
  bit       exp_busy [MAXC];

  clock_gen clocks (.clock(clock), .reset(reset));

  fpu_top uut (
    .clock(clock), .reset(reset), .inst(inst), .valid(valid),
    .fromint_data(fromint_data), .fcsr_rm(fcsr_rm), .killx(killx), .killm(killm),
    .dmem_resp_val(dmem_resp_val), .dmem_resp_tag(dmem_resp_tag),
    .dmem_resp_data(dmem_resp_data), .fcsr_flags_valid(fcsr_flags_valid),
    .fcsr_flags_bits(fcsr_flags_bits), .toint_data(toint_data), .store_data(store_data),
    .fcsr_rdy(fcsr_rdy), .illegal_rm(illegal_rm), .dec_wen(dec_wen),
    .dec_ren1(dec_ren1), .dec_ren2(dec_ren2)
  );

  always @(posedge clock) cycle <= cycle + 1;

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // **************************************************************************
  // Comparing process at the falling edge
  // **************************************************************************
  always @(negedge clock) begin
    if (checking) begin
      check_value(fcsr_flags_valid, exp_fv[cycle], "fcsr_flags_valid");
      check_value(fcsr_flags_bits, exp_fv[cycle] ? exp_bits[cycle] : 5'd0,
                  "fcsr_flags_bits");
      check_value(fcsr_rdy, !exp_busy[cycle], "fcsr_rdy");
      for (int i = ev_cycle.size() - 1; i >= 0; i--) begin
        if (ev_cycle[i] == cycle) begin
          if (ev_store[i]) check_value(store_data, ev_value[i], "store_data");
          else check_value(toint_data, ev_value[i], "toint_data");
          ev_cycle.delete(i);
          ev_store.delete(i);
          ev_value.delete(i);
        end
      end
    end
  end

  initial begin
    #(20 * STIM_CYCLES + 1000);
    $display("watchdog: the run did not finish in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

  function automatic fp_word_t op_fp(logic [4:0] f5, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
    return {f5, 2'b00, rs2, rs1, f3, rd, OPC_OP_FP};
  endfunction

  function automatic fp_word_t enc_fast(fast_op_t op, reg_addr_t rd, reg_addr_t rs1,
                                        reg_addr_t rs2);
    case (op)
      FAST_SGNJ:  return op_fp(F5_SGNJ, 3'd0, rd, rs1, rs2);
      FAST_SGNJN: return op_fp(F5_SGNJ, 3'd1, rd, rs1, rs2);
      FAST_SGNJX: return op_fp(F5_SGNJ, 3'd2, rd, rs1, rs2);
      FAST_MIN:   return op_fp(F5_MINMAX, 3'd0, rd, rs1, rs2);
      FAST_MAX:   return op_fp(F5_MINMAX, 3'd1, rd, rs1, rs2);
      default:    return op_fp(F5_MV_W_X, 3'd0, rd, rs1, 5'd0);
    endcase
  endfunction

  function automatic fp_word_t enc_int(int_op_t op, reg_addr_t rs1, reg_addr_t rs2);
    case (op)
      INT_FEQ:    return op_fp(F5_CMP, 3'd2, 5'd1, rs1, rs2);
      INT_FLT:    return op_fp(F5_CMP, 3'd1, 5'd1, rs1, rs2);
      INT_FLE:    return op_fp(F5_CMP, 3'd0, 5'd1, rs1, rs2);
      INT_CLASS:  return op_fp(F5_MV_X_CLASS, 3'd1, 5'd1, rs1, 5'd0);
      INT_MV_X_W: return op_fp(F5_MV_X_CLASS, 3'd0, 5'd1, rs1, 5'd0);
      default:    return {7'd0, rs2, rs1, 3'b010, 5'd0, OPC_STORE_FP};
    endcase
  endfunction

  task automatic issue(input fp_word_t word);
    inst = word;
    valid = 1'b1;
    @(negedge clock);
    valid = 1'b0;
  endtask

  task automatic mark_busy(input int first, input int last);
    for (int c = first; c <= last; c++) exp_busy[c] = 1'b1;
  endtask

  task automatic expect_event(input int c, input bit is_store, input fp_word_t value);
    ev_cycle.push_back(c);
    ev_store.push_back(is_store);
    ev_value.push_back(value);
  endtask

  task automatic read_reg(input reg_addr_t rs);
    expect_event(cycle + 2, 1'b0, model[rs]);
    issue(enc_int(INT_MV_X_W, rs, 5'd0));
  endtask

  task automatic store_reg(input reg_addr_t rs);
    expect_event(cycle + 2, 1'b1, model[rs]);
    issue(enc_int(INT_STORE, reg_addr_t'($urandom_range(0, 31)), rs));
  endtask

  task automatic load_reg(input reg_addr_t tag, input fp_word_t data);
    dmem_resp_val = 1'b1;
    dmem_resp_tag = tag;
    dmem_resp_data = data;
    model[tag] = data;
    @(negedge clock);
    dmem_resp_val = 1'b0;
  endtask

  // Kill 0 is none, 1 in execute and 2 in memory
  task automatic run_fast(input fast_op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                          input reg_addr_t rs2, input fp_word_t from_int, input int kill);
    fflags_t  fl;
    fp_word_t res;
    int       c;
    c = cycle;
    res = ref_fast(op, model[rs1], model[rs2], from_int, fl);
    if (op == FAST_MIN || op == FAST_MAX) begin
      mark_busy(c + 1, c + 3 - ((kill == 1) ? 2 : (kill == 2) ? 1 : 0));
      if (kill == 0) begin
        exp_fv[c + 3] = 1'b1;
        exp_bits[c + 3] = fl;
      end
    end
    if (kill == 0) model[rd] = res;
    fromint_data = from_int;
    issue(enc_fast(op, rd, rs1, rs2));
    killx = (kill == 1);
    @(negedge clock);
    killx = 1'b0;
    killm = (kill == 2);
    @(negedge clock);
    killm = 1'b0;
  endtask

  task automatic run_cmp(input int_op_t op, input reg_addr_t rs1, input reg_addr_t rs2);
    fflags_t  fl;
    fp_word_t res;
    fp_word_t b;
    int       c;
    c = cycle;
    b = (op == INT_CLASS) ? model[0] : model[rs2];
    res = ref_to_int(op, model[rs1], b, fl);
    expect_event(c + 2, 1'b0, res);
    if (op == INT_FEQ || op == INT_FLT || op == INT_FLE) begin
      exp_fv[c + 3] = 1'b1;
      exp_bits[c + 3] = fl;
      mark_busy(c + 1, c + 3);
    end
    issue(enc_int(op, rs1, rs2));
  endtask

  // Load response lands in the same cycle as the pipeline write
  task automatic write_collision(input reg_addr_t rd, input fp_word_t wb_value,
                                 input fp_word_t load_value);
    fromint_data = wb_value;
    issue(enc_fast(FAST_MV_W_X, rd, 5'd0, 5'd0));
    @(negedge clock);
    load_reg(rd, load_value);
    model[rd] = wb_value;
  endtask

  task automatic check_decode(input fp_word_t word, input rm_t rm);
    logic       w;
    logic       r1;
    logic       r2;
    logic       ill;
    logic [4:0] f5;
    logic [2:0] f3;
    logic       rs2z;
    f5 = word[31:27];
    f3 = word[14:12];
    rs2z = (word[24:20] == 5'd0);
    w = 1'b0;
    r1 = 1'b0;
    r2 = 1'b0;
    ill = (f3 == 3'd5) || (f3 == 3'd6) || ((f3 == 3'd7) && (rm >= 3'd5));
    if (word[6:0] == OPC_LOAD_FP && f3 == 3'd2) w = 1'b1;
    if (word[6:0] == OPC_STORE_FP && f3 == 3'd2) r2 = 1'b1;
    if (word[6:0] == OPC_OP_FP && word[26:25] == 2'b00) begin
      if ((f5 == F5_SGNJ && f3 <= 3'd2) || (f5 == F5_MINMAX && f3 <= 3'd1)) begin
        {w, r1, r2} = 3'b111;
      end
      if (f5 == F5_CMP && f3 <= 3'd2) {r1, r2} = 2'b11;
      if (f5 == F5_MV_X_CLASS && rs2z && f3 <= 3'd1) r1 = 1'b1;
      if (f5 == F5_MV_W_X && rs2z && f3 == 3'd0) w = 1'b1;
    end
    inst = word;
    fcsr_rm = rm;
    #1;
    check_value(dec_wen, w, "dec_wen");
    check_value(dec_ren1, r1, "dec_ren1");
    check_value(dec_ren2, r2, "dec_ren2");
    check_value(illegal_rm, ill, "illegal_rm");
    @(negedge clock);
  endtask

  // **************************************************************************
  // Stimulus
  // **************************************************************************
  initial begin
    fp_word_t   corners [8];
    logic [4:0] f5_list [5];
    logic [6:0] opc_list [3];
    fp_word_t   word;
    reg_addr_t  rd;
    void'($urandom(32'he038_199f));
    inst = '0;
    valid = 1'b0;
    fromint_data = '0;
    fcsr_rm = '0;
    killx = 1'b0;
    killm = 1'b0;
    dmem_resp_val = 1'b0;
    dmem_resp_tag = '0;
    dmem_resp_data = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    corners = '{32'h7fc0_0000, 32'h7f80_0001, 32'h7f80_0000, 32'hff80_0000,
                32'h0000_0000, 32'h8000_0000, 32'hffc0_0001, 32'h0000_0003};
    f5_list = '{F5_SGNJ, F5_MINMAX, F5_CMP, F5_MV_X_CLASS, F5_MV_W_X};
    opc_list = '{OPC_OP_FP, OPC_LOAD_FP, OPC_STORE_FP};

    @(negedge clock);
    while (reset) @(negedge clock);
    checking = 1'b1;

    // Random words in 1 to 8 and corners in 9 to 16
    for (int i = 1; i <= 8; i++) load_reg(reg_addr_t'(i), $urandom);
    for (int i = 9; i <= 16; i++) load_reg(reg_addr_t'(i), corners[i - 9]);
    repeat (3) @(negedge clock);
    for (int i = 1; i <= 16; i++) begin
      read_reg(reg_addr_t'(i));
      store_reg(reg_addr_t'(i));
    end

    for (int i = 0; i < 40; i++) begin
      rd = reg_addr_t'($urandom_range(17, 31));
      run_fast(fast_op_t'($urandom_range(0, 5)), rd, reg_addr_t'($urandom_range(1, 31)),
               reg_addr_t'($urandom_range(1, 31)), $urandom, 0);
      read_reg(rd);
    end

    for (int i = 0; i < 40; i++) begin
      run_cmp(int_op_t'($urandom_range(0, 3)), reg_addr_t'($urandom_range(1, 31)),
              reg_addr_t'($urandom_range(1, 31)));
    end

    for (int i = 0; i < 12; i++) begin
      rd = reg_addr_t'($urandom_range(17, 31));
      run_fast(fast_op_t'($urandom_range(0, 5)), rd, reg_addr_t'($urandom_range(1, 16)),
               reg_addr_t'($urandom_range(1, 16)), $urandom, 1 + (i % 2));
      read_reg(rd);
    end

    write_collision(5'd20, $urandom, $urandom);
    read_reg(5'd20);

    // Each kept operation
    for (int i = 0; i <= 5; i++) begin
      check_decode(enc_fast(fast_op_t'(i), 5'd3, 5'd4, 5'd5), rm_t'($urandom_range(0, 7)));
      check_decode(enc_int(int_op_t'(i), 5'd4, 5'd5), rm_t'($urandom_range(0, 7)));
    end

    // Every rm field with fcsr_rm on both sides of the limit
    for (int f3 = 0; f3 < 8; f3++) begin
      check_decode({17'd0, rm_t'(f3), 5'd2, OPC_LOAD_FP}, 3'd4);
      check_decode({17'd0, rm_t'(f3), 5'd2, OPC_LOAD_FP}, 3'd5);
    end

    for (int i = 0; i < 60; i++) begin
      word = $urandom;
      case (i % 3)
        0: begin
          word[6:0] = OPC_OP_FP;
          word[26:25] = 2'b00;
          word[31:27] = f5_list[$urandom_range(0, 4)];
          if ($urandom_range(0, 1) == 1) word[24:20] = 5'd0;
        end
        1: word[6:0] = opc_list[$urandom_range(0, 2)];
        default: ;
      endcase
      check_decode(word, rm_t'($urandom_range(0, 7)));
    end

    repeat (6) @(negedge clock);
    if (ev_cycle.size() != 0) begin
      errors++;
      $display("%0d expected results were never compared", ev_cycle.size());
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  // 10 ns period
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  wire                     clock,
  input  wire                     reset,
  input  wire fpu_pkg::fp_word_t  inst,
  input  wire                     valid,
  input  wire fpu_pkg::fp_word_t  fromint_data,
  input  wire fpu_pkg::rm_t       fcsr_rm,
  input  wire                     killx,
  input  wire                     killm,
  input  wire                     dmem_resp_val,
  input  wire fpu_pkg::reg_addr_t dmem_resp_tag,
  input  wire fpu_pkg::fp_word_t  dmem_resp_data,
  output logic                    fcsr_flags_valid,
  output fpu_pkg::fflags_t        fcsr_flags_bits,
  output fpu_pkg::fp_word_t       toint_data,
  output fpu_pkg::fp_word_t       store_data,
  output logic                    fcsr_rdy,
  output logic                    illegal_rm,
  output logic                    dec_wen,
  output logic                    dec_ren1,
  output logic                    dec_ren2
);
  import fpu_pkg::*;

  logic      dec_is_fast, dec_is_int, dec_wflags;
  fast_op_t  dec_fast_op;
  int_op_t   dec_int_op;

  // Execute stage
  logic      ex_valid, ex_wen, ex_is_fast, ex_is_int, ex_wflags;
  fast_op_t  ex_fast_op;
  int_op_t   ex_int_op;
  reg_addr_t ex_rd, ex_ra1, ex_ra2;
  fp_word_t  rs1_data, rs2_data;

  // Memory and writeback stages
  logic      mem_valid, mem_wen, mem_is_fast, mem_wflags;
  reg_addr_t mem_rd;
  logic      wb_valid, wb_wen, wb_is_fast, wb_wflags;
  reg_addr_t wb_rd;
  fp_word_t  wb_data;
  fflags_t   wb_fast_flags, wb_int_flags;

  logic      load_val;
  reg_addr_t load_tag;
  fp_word_t  load_data;

  fp_word_t  fast_result;
  fflags_t   fast_flags, int_flags;

  fpu_decoder decoder (
    .inst(inst), .fcsr_rm(fcsr_rm), .wen(dec_wen), .ren1(dec_ren1), .ren2(dec_ren2),
    .is_fast(dec_is_fast), .is_int(dec_is_int), .fast_op(dec_fast_op),
    .int_op(dec_int_op), .wflags(dec_wflags), .illegal_rm(illegal_rm)
  );

  fpu_regfile regfile (
    .clock(clock), .reset(reset), .ra1(ex_ra1), .ra2(ex_ra2), .rd1(rs1_data), .rd2(rs2_data),
    .load_en(load_val), .load_addr(load_tag), .load_data(load_data),
    .wb_en(wb_valid && wb_wen), .wb_addr(wb_rd), .wb_data(wb_data)
  );

  fpu_fast_pipe fast_pipe (
    .clock(clock), .start(ex_valid && ex_is_fast), .op(ex_fast_op), .a(rs1_data),
    .b(rs2_data), .int_in(fromint_data), .result(fast_result), .flags(fast_flags)
  );

  fpu_to_int to_int (
    .clock(clock), .start(ex_valid && ex_is_int), .op(ex_int_op), .a(rs1_data),
    .b(rs2_data), .toint(toint_data), .store(store_data), .flags(int_flags)
  );

  // ******************************************************************
  // Stage valids and kills
  // ******************************************************************
  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid  <= 1'b0;
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
      load_val  <= 1'b0;
    end else begin
      ex_valid  <= valid;
      mem_valid <= ex_valid && !killx;
      wb_valid  <= mem_valid && !killm;
      load_val  <= dmem_resp_val;
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      // FLW sets dec_wen too, but only fast-pipe results go down the pipe
      ex_wen     <= dec_wen && dec_is_fast;
      ex_is_fast <= dec_is_fast;
      ex_is_int  <= dec_is_int;
      ex_wflags  <= dec_wflags;
      ex_fast_op <= dec_fast_op;
      ex_int_op  <= dec_int_op;
      ex_rd      <= inst[11:7];
      ex_ra1     <= inst[19:15];
      ex_ra2     <= inst[24:20];
    end
    if (ex_valid) begin
      mem_wen     <= ex_wen;
      mem_is_fast <= ex_is_fast;
      mem_wflags  <= ex_wflags;
      mem_rd      <= ex_rd;
    end
    if (mem_valid) begin
      wb_wen        <= mem_wen;
      wb_is_fast    <= mem_is_fast;
      wb_wflags     <= mem_wflags;
      wb_rd         <= mem_rd;
      wb_data       <= fast_result;
      wb_fast_flags <= fast_flags;
      wb_int_flags  <= int_flags;
    end
    if (dmem_resp_val) begin
      load_tag  <= dmem_resp_tag;
      load_data <= dmem_resp_data;
    end
  end

  // ******************************************************************
  // Flags and ready
  // ******************************************************************
  assign fcsr_flags_valid = wb_valid && wb_wflags;
  assign fcsr_flags_bits  = !fcsr_flags_valid ? '0 :
                            wb_is_fast ? wb_fast_flags : wb_int_flags;

  assign fcsr_rdy = !((ex_valid && ex_wflags) || (mem_valid && mem_wflags) ||
                      (wb_valid && wb_wflags));

endmodule

`default_nettype wire

//--- logic/fpu_to_int.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_to_int (
  input  wire                    clock,
  input  wire                    start,
  input  wire fpu_pkg::int_op_t  op,
  input  wire fpu_pkg::fp_word_t a,
  input  wire fpu_pkg::fp_word_t b,
  output fpu_pkg::fp_word_t      toint,
  output fpu_pkg::fp_word_t      store,
  output fpu_pkg::fflags_t       flags
);
  import fpu_pkg::*;

  logic       unordered;
  logic       any_snan;
  logic       both_zero;
  logic       eq;
  logic       lt;
  logic       exp_ones;
  logic       exp_zero;
  logic       mant_zero;
  logic [9:0] class_mask;
  fp_word_t   toint_next;
  fflags_t    flags_next;

  assign unordered = is_nan(a) || is_nan(b);
  assign any_snan  = is_snan(a) || is_snan(b);
  assign both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
  assign eq        = !unordered && ((a == b) || both_zero);

  // Magnitude compare; only meaningful when ordered
  always_comb begin
    if (both_zero) begin
      lt = 1'b0;
    end else if (a[31] != b[31]) begin
      lt = a[31];
    end else if (a[31]) begin
      lt = a[30:0] > b[30:0];
    end else begin
      lt = a[30:0] < b[30:0];
    end
  end

  // ******************************************************************
  // FCLASS
  // ******************************************************************
  assign exp_ones  = (a[30:23] == 8'hff);
  assign exp_zero  = (a[30:23] == 8'h00);
  assign mant_zero = (a[22:0] == 23'd0);

  always_comb begin
    class_mask = '0;
    if (exp_ones) begin
      if (!mant_zero) class_mask[a[22] ? 9 : 8] = 1'b1;
      else class_mask[a[31] ? 0 : 7] = 1'b1;
    end else if (exp_zero) begin
      if (mant_zero) class_mask[a[31] ? 3 : 4] = 1'b1;
      else class_mask[a[31] ? 2 : 5] = 1'b1;
    end else begin
      class_mask[a[31] ? 1 : 6] = 1'b1;
    end
  end

  always_comb begin
    flags_next = '0;
    case (op)
      INT_FEQ: begin
        toint_next = {31'd0, eq};
        flags_next[FLAG_NV] = any_snan;
      end
      // Signaling compares, NV on any NaN
      INT_FLT: begin
        toint_next = {31'd0, lt && !unordered};
        flags_next[FLAG_NV] = unordered;
      end
      INT_FLE: begin
        toint_next = {31'd0, (lt && !unordered) || eq};
        flags_next[FLAG_NV] = unordered;
      end
      INT_CLASS:  toint_next = {22'd0, class_mask};
      INT_MV_X_W: toint_next = a;
      default:    toint_next = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (start) begin
      toint <= toint_next;
      store <= b;
      flags <= flags_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/fpu_fast_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_fast_pipe (
  input  wire                    clock,
  input  wire                    start,
  input  wire fpu_pkg::fast_op_t op,
  input  wire fpu_pkg::fp_word_t a,
  input  wire fpu_pkg::fp_word_t b,
  input  wire fpu_pkg::fp_word_t int_in,
  output fpu_pkg::fp_word_t      result,
  output fpu_pkg::fflags_t       flags
);
  import fpu_pkg::*;

  logic     a_nan;
  logic     b_nan;
  logic     a_lt_b;
  fp_word_t min_max;
  fp_word_t result_next;
  fflags_t  flags_next;

  assign a_nan = is_nan(a);
  assign b_nan = is_nan(b);

  // Total order on non-NaN words, -0 below +0
  always_comb begin
    if (a[31] != b[31]) begin
      a_lt_b = a[31];
    end else if (a[31]) begin
      a_lt_b = a[30:0] > b[30:0];
    end else begin
      a_lt_b = a[30:0] < b[30:0];
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      min_max = CANON_NAN;
    end else if (a_nan) begin
      min_max = b;
    end else if (b_nan) begin
      min_max = a;
    end else if (op == FAST_MAX) begin
      min_max = a_lt_b ? b : a;
    end else begin
      min_max = a_lt_b ? a : b;
    end
  end

  always_comb begin
    flags_next = '0;
    case (op)
      FAST_SGNJ:  result_next = {b[31], a[30:0]};
      FAST_SGNJN: result_next = {~b[31], a[30:0]};
      FAST_SGNJX: result_next = {a[31] ^ b[31], a[30:0]};
      FAST_MIN, FAST_MAX: begin
        result_next = min_max;
        flags_next[FLAG_NV] = is_snan(a) || is_snan(b);
      end
      default:    result_next = int_in;
    endcase
  end

  always_ff @(posedge clock) begin
    if (start) begin
      result <= result_next;
      flags  <= flags_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/fpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_regfile (
  input  wire                     clock,
  input  wire                     reset,
  input  wire fpu_pkg::reg_addr_t ra1,
  input  wire fpu_pkg::reg_addr_t ra2,
  output fpu_pkg::fp_word_t       rd1,
  output fpu_pkg::fp_word_t       rd2,
  input  wire                     load_en,
  input  wire fpu_pkg::reg_addr_t load_addr,
  input  wire fpu_pkg::fp_word_t  load_data,
  input  wire                     wb_en,
  input  wire fpu_pkg::reg_addr_t wb_addr,
  input  wire fpu_pkg::fp_word_t  wb_data
);
  import fpu_pkg::*;

  fp_word_t regs [32];

  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (load_en) begin
        regs[load_addr] <= load_data;
      end
      // Pipeline write comes last so it wins on the same address
      if (wb_en) begin
        regs[wb_addr] <= wb_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/fpu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_decoder (
  input  wire fpu_pkg::fp_word_t inst,
  input  wire fpu_pkg::rm_t      fcsr_rm,
  output logic                   wen,
  output logic                   ren1,
  output logic                   ren2,
  output logic                   is_fast,
  output logic                   is_int,
  output fpu_pkg::fast_op_t      fast_op,
  output fpu_pkg::int_op_t       int_op,
  output logic                   wflags,
  output logic                   illegal_rm
);
  import fpu_pkg::*;

  logic [6:0] opcode;
  logic [4:0] funct5;
  logic [2:0] funct3;
  logic       single;
  logic       rs2_zero;

  assign opcode   = inst[6:0];
  assign funct5   = inst[31:27];
  assign funct3   = inst[14:12];
  assign single   = (inst[26:25] == 2'b00);
  assign rs2_zero = (inst[24:20] == 5'd0);

  // rm lives in funct3; 5 and 6 are reserved, DYN defers to fcsr
  assign illegal_rm = (funct3 == 3'd5) || (funct3 == 3'd6) ||
                      ((funct3 == RM_DYN) && (fcsr_rm >= 3'd5));

  always_comb begin
    wen     = 1'b0;
    ren1    = 1'b0;
    ren2    = 1'b0;
    is_fast = 1'b0;
    is_int  = 1'b0;
    fast_op = FAST_SGNJ;
    int_op  = INT_FEQ;
    wflags  = 1'b0;
    case (opcode)
      // FLW writes through the load response port only
      OPC_LOAD_FP: wen = (funct3 == 3'b010);
      OPC_STORE_FP: begin
        if (funct3 == 3'b010) begin
          is_int = 1'b1;
          int_op = INT_STORE;
          ren2   = 1'b1;
        end
      end
      OPC_OP_FP: begin
        if (single) begin
          case (funct5)
            F5_SGNJ: begin
              if (funct3 <= 3'd2) begin
                {wen, ren1, ren2, is_fast} = 4'b1111;
                case (funct3)
                  3'd0:    fast_op = FAST_SGNJ;
                  3'd1:    fast_op = FAST_SGNJN;
                  default: fast_op = FAST_SGNJX;
                endcase
              end
            end
            F5_MINMAX: begin
              if (funct3 <= 3'd1) begin
                {wen, ren1, ren2, is_fast, wflags} = 5'b11111;
                fast_op = (funct3 == 3'd0) ? FAST_MIN : FAST_MAX;
              end
            end
            F5_CMP: begin
              if (funct3 <= 3'd2) begin
                {ren1, ren2, is_int, wflags} = 4'b1111;
                case (funct3)
                  3'd2:    int_op = INT_FEQ;
                  3'd1:    int_op = INT_FLT;
                  default: int_op = INT_FLE;
                endcase
              end
            end
            F5_MV_X_CLASS: begin
              if (rs2_zero && (funct3 <= 3'd1)) begin
                {ren1, is_int} = 2'b11;
                int_op = (funct3 == 3'd0) ? INT_MV_X_W : INT_CLASS;
              end
            end
            F5_MV_W_X: begin
              if (rs2_zero && (funct3 == 3'd0)) begin
                {wen, is_fast} = 2'b11;
                fast_op = FAST_MV_W_X;
              end
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  typedef logic [31:0] fp_word_t;
  typedef logic [4:0]  reg_addr_t;
  // NV, DZ, OF, UF, NX from the top bit down
  typedef logic [4:0]  fflags_t;
  typedef logic [2:0]  rm_t;

  localparam rm_t RM_DYN  = 3'd7;
  localparam int  FLAG_NV = 4;

  // Major opcodes
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

  // funct5 field of OP-FP
  localparam logic [4:0] F5_SGNJ       = 5'b00100;
  localparam logic [4:0] F5_MINMAX     = 5'b00101;
  localparam logic [4:0] F5_CMP        = 5'b10100;
  localparam logic [4:0] F5_MV_X_CLASS = 5'b11100;
  localparam logic [4:0] F5_MV_W_X     = 5'b11110;

  localparam fp_word_t CANON_NAN = 32'h7fc0_0000;

  typedef enum logic [2:0] {
    FAST_SGNJ, FAST_SGNJN, FAST_SGNJX, FAST_MIN, FAST_MAX, FAST_MV_W_X
  } fast_op_t;

  typedef enum logic [2:0] {
    INT_FEQ, INT_FLT, INT_FLE, INT_CLASS, INT_MV_X_W, INT_STORE
  } int_op_t;

  function automatic logic is_nan(fp_word_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // Quiet bit clear
  function automatic logic is_snan(fp_word_t x);
    return is_nan(x) && !x[22];
  endfunction

endpackage

`default_nettype wire
